// ==== Bender.yml ====
package:
  name: yuv_to_rgb

sources:
  - files:
      - rtl/csc_pkg.sv
      - rtl/chroma_upsampler.sv
      - rtl/color_matrix.sv
      - rtl/yuv_to_rgb_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_yuv_to_rgb.sv

// ==== all.f ====
+incdir+sim
rtl/csc_pkg.sv
rtl/chroma_upsampler.sv
rtl/color_matrix.sv
rtl/yuv_to_rgb_top.sv
sim/tb_yuv_to_rgb.sv

// ==== rtl/chroma_upsampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroma_upsampler import csc_pkg::*; #(
	parameter int row_pairs = 160
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_valid,
	input logic row_start,
	input pixel_t sample,
	output logic c_valid,
	output chroma_pair_t c_out
);

	localparam int CNT_W = $clog2(row_pairs + 1);
	localparam int FL_W = $clog2(LOOKAHEAD + 1);

	pixel_t win [6];          // Samples j-2 .. j+3, newest at the top
	logic [CNT_W-1:0] pair_cnt;  // Pairs accepted in this row
	logic [CNT_W-1:0] next_cnt;
	logic [FL_W-1:0] flush_left;
	logic flushing;
	logic last_pair;
	acc_t filt_sum;

	assign flushing = (flush_left != '0);
	assign next_cnt = row_start ? CNT_W'(1) : pair_cnt + 1'b1;
	assign last_pair = in_valid && (next_cnt == row_pairs);

	// Control path
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			pair_cnt <= '0;
			flush_left <= '0;
			c_valid <= 1'b0;
		end else begin
			c_valid <= 1'b0;
			if (in_valid) begin
				pair_cnt <= next_cnt;
				// Window is full once LOOKAHEAD pairs sit ahead of the centre
				if (!row_start && pair_cnt >= LOOKAHEAD) begin
					c_valid <= 1'b1;
				end
				if (last_pair) begin
					flush_left <= FL_W'(LOOKAHEAD);
				end
			end else if (flushing) begin
				flush_left <= flush_left - 1'b1;
				c_valid <= 1'b1; // One output per flush step
			end
		end
	end

	// Sample window
	always_ff @(posedge CLOCK_50_I) begin
		if (in_valid && row_start) begin
			// Left edge clamp
			for (int i = 0; i < 6; i++) begin
				win[i] <= sample;
			end
		end else if (in_valid || flushing) begin
			for (int i = 0; i < 5; i++) begin
				win[i] <= win[i+1];
			end
			win[5] <= in_valid ? sample : win[5]; // Right edge repeats last sample
		end
	end

	always_comb begin
		filt_sum = TAP_OUTER * (acc_t'(win[0]) + acc_t'(win[5]))
			- TAP_MIDDLE * (acc_t'(win[1]) + acc_t'(win[4]))
			+ TAP_INNER * (acc_t'(win[2]) + acc_t'(win[3]))
			+ FILTER_ROUND;
	end

	assign c_out.c_even = win[2];
	assign c_out.c_odd = clip_pixel(filt_sum >>> FILTER_SHIFT);

	// Source leaves enough idle cycles for the flush to finish
	a_no_input_in_flush: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		flushing |-> !in_valid
	);

	a_cnt_in_range: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		pair_cnt <= row_pairs
	);

endmodule

`default_nettype wire

// ==== rtl/color_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_matrix import csc_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_valid,
	input pixel_t y_even,
	input pixel_t y_odd,
	input logic c_valid,
	input chroma_pair_t u_pair,
	input logic v_valid,
	input chroma_pair_t v_pair,
	output logic out_valid,
	output rgb_pair_t out_pair
);

	localparam int FIFO_DEPTH = LOOKAHEAD + 2;
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int FCNT_W = $clog2(FIFO_DEPTH + 1);

	typedef struct packed {
		pixel_t even;
		pixel_t odd;
	} luma_t;

	// Products for one pixel
	typedef struct packed {
		acc_t y;
		acc_t rv;
		acc_t gu;
		acc_t gv;
		acc_t bu;
	} prod_t;

	luma_t luma_mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [FCNT_W-1:0] fifo_cnt;
	luma_t y_head;

	logic s1_valid;
	prod_t prod_even;
	prod_t prod_odd;

	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	function automatic prod_t form_products(pixel_t y, pixel_t u, pixel_t v);
		acc_t y_off;
		acc_t u_off;
		acc_t v_off;
		prod_t p;
		y_off = acc_t'(y) - Y_OFFSET_VAL;
		u_off = acc_t'(u) - C_OFFSET_VAL;
		v_off = acc_t'(v) - C_OFFSET_VAL;
		p.y = acc_t'(K_Y) * y_off;
		p.rv = acc_t'(K_RV) * v_off;
		p.gu = acc_t'(K_GU) * u_off;
		p.gv = acc_t'(K_GV) * v_off;
		p.bu = acc_t'(K_BU) * u_off;
		return p;
	endfunction

	// Arithmetic shift floors toward minus infinity
	function automatic rgb_t form_rgb(prod_t p);
		rgb_t px;
		px.r = clip_pixel((p.y + p.rv) >>> MATRIX_SHIFT);
		px.g = clip_pixel((p.y - p.gu - p.gv) >>> MATRIX_SHIFT);
		px.b = clip_pixel((p.y + p.bu) >>> MATRIX_SHIFT);
		return px;
	endfunction

	assign y_head = luma_mem[rd_ptr];

	// Luma waits here for its upsampled chroma
	always_ff @(posedge CLOCK_50_I) begin
		if (in_valid) begin
			luma_mem[wr_ptr] <= '{even: y_even, odd: y_odd};
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (c_valid) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({in_valid, c_valid})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	// Valid pipeline, two stages
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= c_valid;
			out_valid <= s1_valid;
		end
	end

	// Stage one multiplies
	always_ff @(posedge CLOCK_50_I) begin
		if (c_valid) begin
			prod_even <= form_products(y_head.even, u_pair.c_even, v_pair.c_even);
			prod_odd <= form_products(y_head.odd, u_pair.c_odd, v_pair.c_odd);
		end
	end

	// Stage two sums, shifts and clips
	always_ff @(posedge CLOCK_50_I) begin
		if (s1_valid) begin
			out_pair.even <= form_rgb(prod_even);
			out_pair.odd <= form_rgb(prod_odd);
		end
	end

	// Both upsamplers must stay in lock-step
	a_chroma_lockstep: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		c_valid == v_valid
	);

	a_luma_fifo_level: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		!((c_valid && fifo_cnt == '0) ||
			(in_valid && !c_valid && fifo_cnt == FCNT_W'(FIFO_DEPTH)))
	);

endmodule

`default_nettype wire

// ==== rtl/csc_pkg.sv ====
`default_nettype none

package csc_pkg;

	localparam int PIXEL_W = 8;
	localparam int COEF_W = 19;
	localparam int ACC_W = 32;

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// One input pair, chroma subsampled by two
	typedef struct packed {
		pixel_t y_even;
		pixel_t y_odd;
		pixel_t u;
		pixel_t v;
	} yuv_pair_t;

	typedef struct packed {
		pixel_t c_even; // Copied sample
		pixel_t c_odd;  // Interpolated sample
	} chroma_pair_t;

	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	typedef struct packed {
		rgb_t even;
		rgb_t odd;
	} rgb_pair_t;

	// Six-tap interpolation, taps sum to 256
	localparam acc_t TAP_OUTER = 21;
	localparam acc_t TAP_MIDDLE = 52; // Subtracted
	localparam acc_t TAP_INNER = 159;
	localparam acc_t FILTER_ROUND = 128;
	localparam int FILTER_SHIFT = 8;

	localparam acc_t Y_OFFSET_VAL = 16;
	localparam acc_t C_OFFSET_VAL = 128;
	localparam acc_t PIXEL_MAX = 255;

	// Colour matrix in 16.16 fixed point
	localparam coef_t K_Y = 76284;
	localparam coef_t K_RV = 104595;
	localparam coef_t K_GU = 25624;  // Subtracted
	localparam coef_t K_GV = 53281;  // Subtracted
	localparam coef_t K_BU = 132251;
	localparam int MATRIX_SHIFT = 16;

	localparam int LOOKAHEAD = 3; // Pairs needed past the current one

	// Saturate a signed result into 0..255
	function automatic pixel_t clip_pixel(acc_t value);
		if (value < 0) begin
			return '0;
		end
		if (value > PIXEL_MAX) begin
			return '1;
		end
		return pixel_t'(value);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/yuv_to_rgb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module yuv_to_rgb_top import csc_pkg::*; #(
	parameter int row_pairs = 160
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_valid,
	input logic row_start,
	input yuv_pair_t in_pair,
	output logic out_valid,
	output rgb_pair_t out_pair
);

	logic u_valid;
	logic v_valid;
	chroma_pair_t u_chroma;
	chroma_pair_t v_chroma;

	chroma_upsampler #(
		.row_pairs(row_pairs)
	) u_upsample_u (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.row_start(row_start),
		.sample(in_pair.u),
		.c_valid(u_valid),
		.c_out(u_chroma)
	);

	chroma_upsampler #(
		.row_pairs(row_pairs)
	) u_upsample_v (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.row_start(row_start),
		.sample(in_pair.v),
		.c_valid(v_valid),
		.c_out(v_chroma)
	);

	// U strobe drives the matrix, V strobe only cross-checks it
	color_matrix u_color_matrix (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.y_even(in_pair.y_even),
		.y_odd(in_pair.y_odd),
		.c_valid(u_valid),
		.u_pair(u_chroma),
		.v_valid(v_valid),
		.v_pair(v_chroma),
		.out_valid(out_valid),
		.out_pair(out_pair)
	);

endmodule

`default_nettype wire

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Positions outside the row take the nearest edge sample
function automatic int clamp_pos(int pos, int n);
	if (pos < 0) begin
		return 0;
	end
	if (pos > n - 1) begin
		return n - 1;
	end
	return pos;
endfunction

function automatic int saturate(int value);
	if (value < 0) begin
		return 0;
	end
	if (value > 255) begin
		return 255;
	end
	return value;
endfunction

// Half-sample point between s2 and s3
function automatic int interpolate_odd(int s0, int s1, int s2, int s3, int s4, int s5);
	int sum;
	sum = int'(TAP_OUTER) * (s0 + s5) - int'(TAP_MIDDLE) * (s1 + s4)
		+ int'(TAP_INNER) * (s2 + s3) + int'(FILTER_ROUND);
	return saturate(sum >>> 8);
endfunction

function automatic rgb_t pixel_to_rgb(int y, int u, int v);
	int y_term;
	int u_off;
	int v_off;
	rgb_t px;
	y_term = int'(K_Y) * (y - int'(Y_OFFSET_VAL));
	u_off = u - int'(C_OFFSET_VAL);
	v_off = v - int'(C_OFFSET_VAL);
	px.r = pixel_t'(saturate((y_term + int'(K_RV) * v_off) >>> MATRIX_SHIFT));
	px.g = pixel_t'(saturate((y_term - int'(K_GU) * u_off - int'(K_GV) * v_off) >>> MATRIX_SHIFT));
	px.b = pixel_t'(saturate((y_term + int'(K_BU) * u_off) >>> MATRIX_SHIFT)); // Floor shift
	return px;
endfunction

`endif

// ==== sim/tb_yuv_to_rgb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_yuv_to_rgb import csc_pkg::*; ();

	localparam int ROW_PAIRS = 8;
	localparam int NUM_ROWS = 6;
	localparam int TOTAL_PAIRS = ROW_PAIRS * NUM_ROWS;
	localparam int PAIR_SPACING = 3;
	localparam int ROW_GAP = 8;
	localparam int CLK_PERIOD = 10;
	localparam int WATCHDOG_NS = NUM_ROWS * (ROW_PAIRS * PAIR_SPACING + ROW_GAP) * CLK_PERIOD * 2;

	logic CLOCK_50_I = 1'b0;
	logic resetn;
	logic in_valid;
	logic row_start;
	yuv_pair_t in_pair;
	logic out_valid;
	rgb_pair_t out_pair;

	yuv_pair_t stim [TOTAL_PAIRS];
	rgb_pair_t exp_out [TOTAL_PAIRS];
	logic [15:0] lfsr_state;
	int pairs_driven = 0;
	int out_count = 0;
	logic failed = 1'b0;

	`include "tb_model.svh"

	yuv_to_rgb_top #(
		.row_pairs(ROW_PAIRS)
	) u_yuv_to_rgb_top (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.row_start(row_start),
		.in_pair(in_pair),
		.out_valid(out_valid),
		.out_pair(out_pair)
	);

	always #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_byte(output pixel_t value);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[6:0], lfsr_state[0]}; // One step per bit
		end
	endtask

	task automatic build_table();
		int idx;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int j = 0; j < ROW_PAIRS; j++) begin
				idx = r * ROW_PAIRS + j;
				if (r < 4) begin
					random_byte(stim[idx].y_even);
					random_byte(stim[idx].y_odd);
					random_byte(stim[idx].u);
					random_byte(stim[idx].v);
				end else if (r == 4) begin
					// Dark row pushes channels below zero
					stim[idx] = '{y_even: 8'd0, y_odd: 8'd0,
						u: (j % 2) ? 8'd255 : 8'd0, v: (j % 2) ? 8'd0 : 8'd255};
				end else begin
					stim[idx] = '{y_even: 8'd255, y_odd: 8'd255,
						u: (j % 2) ? 8'd0 : 8'd255, v: (j % 2) ? 8'd255 : 8'd0};
				end
			end
		end
	endtask

	task automatic compute_expected();
		int base;
		int us [6];
		int vs [6];
		for (int r = 0; r < NUM_ROWS; r++) begin
			base = r * ROW_PAIRS;
			for (int j = 0; j < ROW_PAIRS; j++) begin
				for (int k = 0; k < 6; k++) begin
					us[k] = stim[base + clamp_pos(j - 2 + k, ROW_PAIRS)].u;
					vs[k] = stim[base + clamp_pos(j - 2 + k, ROW_PAIRS)].v;
				end
				exp_out[base + j].even = pixel_to_rgb(stim[base + j].y_even, us[2], vs[2]);
				exp_out[base + j].odd = pixel_to_rgb(stim[base + j].y_odd,
					interpolate_odd(us[0], us[1], us[2], us[3], us[4], us[5]),
					interpolate_odd(vs[0], vs[1], vs[2], vs[3], vs[4], vs[5]));
			end
		end
	endtask

	task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
		if (got !== expected) begin
			failed = 1'b1;
			$display("Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	initial begin
		resetn = 1'b0;
		in_valid = 1'b0;
		row_start = 1'b0;
		in_pair = '0;
		lfsr_state = 16'd6508;
		build_table();
		compute_expected();
		repeat (8) @(posedge CLOCK_50_I);
		resetn <= 1'b1;
		repeat (2) @(posedge CLOCK_50_I);
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int j = 0; j < ROW_PAIRS; j++) begin
				@(posedge CLOCK_50_I);
				in_valid <= 1'b1;
				row_start <= (j == 0);
				in_pair <= stim[r * ROW_PAIRS + j];
				pairs_driven <= pairs_driven + 1;
				@(posedge CLOCK_50_I);
				in_valid <= 1'b0;
				row_start <= 1'b0;
				@(posedge CLOCK_50_I);
			end
			repeat (ROW_GAP) @(posedge CLOCK_50_I);
			check_value("out_count", out_count, (r + 1) * ROW_PAIRS); // Row fully drained
		end
		repeat (ROW_GAP) @(posedge CLOCK_50_I); // Late strays after the last row
		check_value("out_count", out_count, TOTAL_PAIRS);
		if (!failed) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1);
		end
	end

	// Outputs are read away from the active edge
	always @(negedge CLOCK_50_I) begin
		if (resetn && out_valid) begin
			if (pairs_driven < 4) begin
				$display("out_valid rose before the fourth pair of the first row was driven");
				$display("test failed");
				$fatal(1);
			end else if (out_count >= TOTAL_PAIRS) begin
				$display("out_valid pulsed more often than pairs were sent");
				$display("test failed");
				$fatal(1);
			end else begin
				check_value($sformatf("out_pair[%0d]", out_count), out_pair, exp_out[out_count]);
				out_count = out_count + 1;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Outputs stopped before all expected pairs arrived");
		$display("test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire
